// File: build.f
+incdir+.
csr_pkg.sv
csr_decode.sv
csr_execute.sv
csr_file.sv
csr_result.sv
csr_unit.sv
csr_unit_tb.sv

// File: csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// machine csr addresses.
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344
`define CSR_MCYCLE    12'hb00
`define CSR_MINSTRET  12'hb02
`define CSR_MCYCLEH   12'hb80
`define CSR_MINSTRETH 12'hb82
`define CSR_MVENDORID 12'hf11
`define CSR_MARCHID   12'hf12
`define CSR_MIMPID    12'hf13
`define CSR_MHARTID   12'hf14

`define OPCODE_SYSTEM 7'b1110011

`define FUNCT3_CSRRW  3'b001
`define FUNCT3_CSRRS  3'b010
`define FUNCT3_CSRRC  3'b011
`define FUNCT3_CSRRWI 3'b101
`define FUNCT3_CSRRSI 3'b110
`define FUNCT3_CSRRCI 3'b111

`define MRET_INSTR 32'h30200073

// rv32 with i, m and u.
`define MISA_VALUE 32'h40101100

`define CAUSE_ILLEGAL 4'd2
`define IRQ_M_SOFT    4'd3
`define IRQ_M_TIMER   4'd7
`define IRQ_M_EXT     4'd11

`define PRIV_M 2'b11
`define PRIV_U 2'b00

`define MTVEC_VECTORED 2'b01

`endif

// File: csr_decode.sv
`default_nettype none
`timescale 1ns/1ns

`include "csr_consts.svh"

module csr_decode (
  input  csr_pkg::csr_issue_t   issue,
  output csr_pkg::csr_decoded_t dec
);
  import csr_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] rs1_field;
  logic [4:0] rd_field;
  csr_addr_t  addr;
  csr_op_e    op;
  logic       is_csr;
  logic       is_mret;
  logic       known;
  logic       read_only;
  logic       write_en;

  assign opcode    = issue.instr[6:0];
  assign rd_field  = issue.instr[11:7];
  assign funct3    = issue.instr[14:12];
  assign rs1_field = issue.instr[19:15];
  assign addr      = issue.instr[31:20];
  assign is_mret   = issue.instr == `MRET_INSTR;

  always_comb begin
    op = op_none;
    is_csr = 1'b0;
    if (opcode == `OPCODE_SYSTEM) begin
      case (funct3)
        `FUNCT3_CSRRW, `FUNCT3_CSRRWI: begin
          op = op_write;
          is_csr = 1'b1;
        end
        `FUNCT3_CSRRS, `FUNCT3_CSRRSI: begin
          op = op_set;
          is_csr = 1'b1;
        end
        `FUNCT3_CSRRC, `FUNCT3_CSRRCI: begin
          op = op_clear;
          is_csr = 1'b1;
        end
        default: op = op_none;   // mret, ecall, wfi and the rest.
      endcase
    end
  end

  always_comb begin
    case (addr)
      `CSR_MSTATUS, `CSR_MISA, `CSR_MIE, `CSR_MTVEC, `CSR_MSCRATCH,
      `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_MIP,
      `CSR_MCYCLE, `CSR_MINSTRET, `CSR_MCYCLEH, `CSR_MINSTRETH,
      `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID: known = 1'b1;
      default: known = 1'b0;
    endcase
  end

  // id registers all sit in the 0xfxx read-only space.
  assign read_only = (addr[11:10] == 2'b11) || (addr == `CSR_MISA);

  // set and clear with x0 or a zero immediate do not write.
  assign write_en = is_csr && ((op == op_write) || (rs1_field != 5'd0));

  always_comb begin
    dec.valid       = issue.valid;
    dec.op          = op;
    dec.addr        = addr;
    dec.rd          = rd_field;
    dec.source      = funct3[2] ? {27'd0, rs1_field} : issue.rs1_data;
    dec.source_zero = rs1_field == 5'd0;
    dec.read_en     = is_csr && !((op == op_write) && (rd_field == 5'd0));
    dec.write_en    = write_en;
    dec.is_mret     = issue.valid && is_mret;
    dec.illegal     = issue.valid &&
                      !(is_mret || (is_csr && known && !(write_en && read_only)));
  end

endmodule

`default_nettype wire

// File: csr_execute.sv
`default_nettype none
`timescale 1ns/1ns

module csr_execute (
  input  csr_pkg::csr_decoded_t dec,
  input  csr_pkg::xlen_t        rdata,
  output csr_pkg::csr_write_t   wr,
  output csr_pkg::xlen_t        rd_data
);
  import csr_pkg::*;

  xlen_t new_value;
  logic  write_ok;

  always_comb begin
    case (dec.op)
      op_write: new_value = dec.source;
      op_set:   new_value = rdata | dec.source;
      op_clear: new_value = rdata & ~dec.source;
      default:  new_value = rdata;
    endcase
  end

  // traps are masked inside the register file.
  assign write_ok = dec.valid && !dec.illegal && dec.write_en;

  always_comb begin
    wr.en   = write_ok;
    wr.addr = dec.addr;
    wr.data = new_value;
  end

  // csrrw to x0 has no read side effect.
  assign rd_data = dec.read_en ? rdata : '0;

endmodule

`default_nettype wire

// File: csr_file.sv
`default_nettype none
`timescale 1ns/1ns

`include "csr_consts.svh"

module csr_file (
  input  logic                clock,
  input  logic                reset,
  input  logic                issue_valid,
  input  csr_pkg::xlen_t      pc,
  input  csr_pkg::xlen_t      instr,
  input  csr_pkg::csr_addr_t  raddr,
  output csr_pkg::xlen_t      rdata,
  input  csr_pkg::csr_write_t wr,
  input  logic                illegal,
  input  logic                mret,
  input  logic                meip,
  input  logic                mtip,
  input  logic                msip,
  output csr_pkg::csr_trap_t  trap,
  output logic                trapped
);
  import csr_pkg::*;

  mstatus_t mstatus;
  mie_t     mie;
  mip_t     mip;
  xlen_t    mtvec;
  xlen_t    mscratch;
  xlen_t    mepc;
  xlen_t    mcause;
  xlen_t    mtval;
  counter_t mcycle;
  counter_t minstret;
  logic     take_q;
  logic     mret_q;
  logic     irq_pending;
  cause_t   irq_cause;
  logic     mret_fire;

  assign irq_pending = mstatus.mie && ((mie.meie && mip.meip) ||
                                       (mie.mtie && mip.mtip) ||
                                       (mie.msie && mip.msip));

  // external, then timer, then software.
  always_comb begin
    if (mie.meie && mip.meip) begin
      irq_cause = `IRQ_M_EXT;
    end else if (mie.mtie && mip.mtip) begin
      irq_cause = `IRQ_M_TIMER;
    end else begin
      irq_cause = `IRQ_M_SOFT;
    end
  end

  assign trapped   = issue_valid && (illegal || irq_pending);
  assign mret_fire = issue_valid && mret && !trapped;

  always_comb begin
    case (raddr)
      `CSR_MSTATUS:   rdata = mstatus;
      `CSR_MISA:      rdata = `MISA_VALUE;
      `CSR_MIE:       rdata = mie;
      `CSR_MTVEC:     rdata = mtvec;
      `CSR_MSCRATCH:  rdata = mscratch;
      `CSR_MEPC:      rdata = mepc;
      `CSR_MCAUSE:    rdata = mcause;
      `CSR_MTVAL:     rdata = mtval;
      `CSR_MIP:       rdata = mip;
      `CSR_MCYCLE:    rdata = mcycle[31:0];
      `CSR_MCYCLEH:   rdata = mcycle[63:32];
      `CSR_MINSTRET:  rdata = minstret[31:0];
      `CSR_MINSTRETH: rdata = minstret[63:32];
      `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID: rdata = '0;
      default:        rdata = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      mstatus  <= '0;
      mie      <= '0;
      mip      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
      mcycle   <= '0;
      minstret <= '0;
      take_q   <= 1'b0;
      mret_q   <= 1'b0;
    end else begin
      mcycle <= mcycle + 64'd1;
      if (issue_valid && !trapped) begin
        minstret <= minstret + 64'd1;   // mret retires too.
      end

      // levels are sampled here and read by the next issue.
      mip.meip <= meip;
      mip.mtip <= mtip;
      mip.msip <= msip;

      take_q <= trapped;
      mret_q <= mret_fire;

      if (trapped) begin
        mstatus.mpie <= mstatus.mie;
        mstatus.mie  <= 1'b0;
        mstatus.mpp  <= `PRIV_M;
        mepc         <= pc;
        if (illegal) begin
          mcause <= {28'd0, `CAUSE_ILLEGAL};
          mtval  <= instr;
        end else begin
          mcause <= {1'b1, 27'd0, irq_cause};
          mtval  <= '0;
        end
      end else if (mret_fire) begin
        mstatus.mie  <= mstatus.mpie;
        mstatus.mpie <= 1'b1;
        mstatus.mpp  <= `PRIV_U;   // lowest supported mode.
      end else if (wr.en) begin
        // counter writes land after the increment above and win.
        case (wr.addr)
          `CSR_MSTATUS: begin
            mstatus.mie  <= wr.data[3];
            mstatus.mpie <= wr.data[7];
            if (wr.data[12:11] == `PRIV_M || wr.data[12:11] == `PRIV_U) begin
              mstatus.mpp <= wr.data[12:11];
            end
          end
          `CSR_MIE: begin
            mie.meie <= wr.data[11];
            mie.mtie <= wr.data[7];
            mie.msie <= wr.data[3];
          end
          `CSR_MTVEC:     mtvec <= {wr.data[31:2], 1'b0, wr.data[0]};   // direct or vectored.
          `CSR_MSCRATCH:  mscratch <= wr.data;
          `CSR_MEPC:      mepc <= {wr.data[31:2], 2'b00};
          `CSR_MCAUSE:    mcause <= wr.data;
          `CSR_MTVAL:     mtval <= wr.data;
          `CSR_MCYCLE:    mcycle[31:0] <= wr.data;
          `CSR_MCYCLEH:   mcycle[63:32] <= wr.data;
          `CSR_MINSTRET:  minstret[31:0] <= wr.data;
          `CSR_MINSTRETH: minstret[63:32] <= wr.data;
          default: ;   // mip has no writable machine bits.
        endcase
      end
    end
  end

  always_comb begin
    trap.take      = take_q;
    trap.mret      = mret_q;
    trap.interrupt = mcause[31];
    trap.cause     = mcause[3:0];
    trap.mtvec     = mtvec;
    trap.mepc      = mepc;
  end

endmodule

`default_nettype wire

// File: csr_pkg.sv
`default_nettype none

package csr_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [3:0]  cause_t;
  typedef logic [63:0] counter_t;

  typedef enum logic [1:0] {
    op_none,
    op_write,
    op_set,
    op_clear
  } csr_op_e;

  // architectural bit layout, only the machine fields are kept.
  typedef struct packed {
    logic [18:0] zero_hi;
    logic [1:0]  mpp;
    logic [2:0]  zero_10_8;
    logic        mpie;
    logic [2:0]  zero_6_4;
    logic        mie;
    logic [2:0]  zero_2_0;
  } mstatus_t;

  typedef struct packed {
    logic [19:0] zero_hi;
    logic        meie;
    logic [2:0]  zero_10_8;
    logic        mtie;
    logic [2:0]  zero_6_4;
    logic        msie;
    logic [2:0]  zero_2_0;
  } mie_t;

  typedef struct packed {
    logic [19:0] zero_hi;
    logic        meip;
    logic [2:0]  zero_10_8;
    logic        mtip;
    logic [2:0]  zero_6_4;
    logic        msip;
    logic [2:0]  zero_2_0;
  } mip_t;

  typedef struct packed {
    logic  valid;
    xlen_t instr;
    xlen_t rs1_data;
    xlen_t pc;
  } csr_issue_t;

  typedef struct packed {
    logic      valid;
    csr_op_e   op;
    csr_addr_t addr;
    logic [4:0] rd;
    xlen_t     source;
    logic      source_zero;
    logic      read_en;
    logic      write_en;
    logic      is_mret;
    logic      illegal;
  } csr_decoded_t;

  typedef struct packed {
    logic      en;
    csr_addr_t addr;
    xlen_t     data;
  } csr_write_t;

  typedef struct packed {
    logic   take;      // trap or interrupt entered.
    logic   mret;
    logic   interrupt;
    cause_t cause;
    xlen_t  mtvec;
    xlen_t  mepc;
  } csr_trap_t;

  typedef struct packed {
    logic       valid;
    logic [4:0] rd;
    xlen_t      rd_data;
  } csr_result_t;

  typedef struct packed {
    logic  valid;
    xlen_t pc;
  } csr_redirect_t;

endpackage

`default_nettype wire

// File: csr_result.sv
`default_nettype none
`timescale 1ns/1ns

`include "csr_consts.svh"

module csr_result (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   issue_valid,
  input  logic                   trapped,
  input  logic                   is_mret,
  input  logic [4:0]             rd,
  input  csr_pkg::xlen_t         rd_data,
  input  csr_pkg::csr_trap_t     trap,
  output csr_pkg::csr_result_t   result,
  output csr_pkg::csr_redirect_t redirect
);
  import csr_pkg::*;

  logic       valid_q;
  logic [4:0] rd_q;
  xlen_t      rd_data_q;
  xlen_t      base;

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_valid && !trapped && !is_mret;
    end
  end

  always_ff @(posedge clock) begin
    rd_q      <= rd;
    rd_data_q <= rd_data;
  end

  always_comb begin
    result.valid   = valid_q;
    result.rd      = rd_q;
    result.rd_data = rd_data_q;
  end

  assign base = {trap.mtvec[31:2], 2'b00};

  // trap record is already registered, so this lines up with result.
  always_comb begin
    redirect.valid = trap.take || trap.mret;
    if (trap.mret) begin
      redirect.pc = trap.mepc;
    end else if (trap.interrupt && trap.mtvec[1:0] == `MTVEC_VECTORED) begin
      redirect.pc = base + {26'd0, trap.cause, 2'b00};
    end else begin
      redirect.pc = base;
    end
  end

endmodule

`default_nettype wire

// File: csr_unit.sv
`default_nettype none
`timescale 1ns/1ns

module csr_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  csr_pkg::csr_issue_t    issue,
  input  logic                   meip,
  input  logic                   mtip,
  input  logic                   msip,
  output csr_pkg::csr_result_t   result,
  output csr_pkg::csr_redirect_t redirect
);
  import csr_pkg::*;

  csr_decoded_t dec;
  csr_write_t   wr;
  csr_trap_t    trap;
  xlen_t        rdata;
  xlen_t        rd_data;
  logic         trapped;

  csr_decode i_decode (
    .issue (issue),
    .dec   (dec)
  );

  csr_execute i_execute (
    .dec     (dec),
    .rdata   (rdata),
    .wr      (wr),
    .rd_data (rd_data)
  );

  csr_file i_file (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue.valid),
    .pc          (issue.pc),
    .instr       (issue.instr),
    .raddr       (dec.addr),
    .rdata       (rdata),
    .wr          (wr),
    .illegal     (dec.illegal),
    .mret        (dec.is_mret),
    .meip        (meip),
    .mtip        (mtip),
    .msip        (msip),
    .trap        (trap),
    .trapped     (trapped)
  );

  csr_result i_result (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue.valid),
    .trapped     (trapped),
    .is_mret     (dec.is_mret),
    .rd          (dec.rd),
    .rd_data     (rd_data),
    .trap        (trap),
    .result      (result),
    .redirect    (redirect)
  );

endmodule

`default_nettype wire

// File: csr_unit_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "csr_consts.svh"

module csr_unit_tb;
  import csr_pkg::*;

  localparam int clock_period = 4;
  localparam int n_random     = 150;
  // reset, two cycles per random op, then about 70 directed cycles and a margin.
  localparam int test_cycles  = 4 + 2 * n_random + 120;

  logic          clock;
  logic          reset;
  csr_issue_t    issue;
  logic          meip;
  logic          mtip;
  logic          msip;
  csr_result_t   result;
  csr_redirect_t redirect;

  csr_result_t   exp_result;
  csr_redirect_t exp_redirect;
  logic          checking;
  string         test_name;
  integer        seed;
  xlen_t         next_pc;

  // model copies of the machine registers.
  mstatus_t m_mstatus;
  mie_t     m_mie;
  mip_t     m_mip;
  xlen_t    m_mtvec;
  xlen_t    m_mscratch;
  xlen_t    m_mepc;
  xlen_t    m_mcause;
  xlen_t    m_mtval;
  counter_t m_mcycle;
  counter_t m_minstret;

  csr_unit i_dut (
    .clock    (clock),
    .reset    (reset),
    .issue    (issue),
    .meip     (meip),
    .mtip     (mtip),
    .msip     (msip),
    .result   (result),
    .redirect (redirect)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  function automatic xlen_t encode_csr(input logic [2:0] f3, input csr_addr_t addr,
                                       input logic [4:0] rs1, input logic [4:0] rd);
    return {addr, rs1, f3, rd, `OPCODE_SYSTEM};
  endfunction

  function automatic xlen_t model_read(input csr_addr_t a);
    case (a)
      `CSR_MSTATUS:   return m_mstatus;
      `CSR_MISA:      return `MISA_VALUE;
      `CSR_MIE:       return m_mie;
      `CSR_MTVEC:     return m_mtvec;
      `CSR_MSCRATCH:  return m_mscratch;
      `CSR_MEPC:      return m_mepc;
      `CSR_MCAUSE:    return m_mcause;
      `CSR_MTVAL:     return m_mtval;
      `CSR_MIP:       return m_mip;
      `CSR_MCYCLE:    return m_mcycle[31:0];
      `CSR_MCYCLEH:   return m_mcycle[63:32];
      `CSR_MINSTRET:  return m_minstret[31:0];
      `CSR_MINSTRETH: return m_minstret[63:32];
      default:        return '0;   // id registers read as zero.
    endcase
  endfunction

  function automatic void model_write(input csr_addr_t a, input xlen_t v);
    case (a)
      `CSR_MSTATUS: begin
        m_mstatus.mie  = v[3];
        m_mstatus.mpie = v[7];
        if (v[12:11] == `PRIV_M || v[12:11] == `PRIV_U) begin
          m_mstatus.mpp = v[12:11];   // only m and u exist.
        end
      end
      `CSR_MIE: begin
        m_mie.meie = v[11];
        m_mie.mtie = v[7];
        m_mie.msie = v[3];
      end
      `CSR_MTVEC:     m_mtvec = v & 32'hffff_fffd;   // modes 2 and 3 are reserved.
      `CSR_MSCRATCH:  m_mscratch = v;
      `CSR_MEPC:      m_mepc = v & ~32'd3;
      `CSR_MCAUSE:    m_mcause = v;
      `CSR_MTVAL:     m_mtval = v;
      `CSR_MCYCLE:    m_mcycle[31:0] = v;
      `CSR_MCYCLEH:   m_mcycle[63:32] = v;
      `CSR_MINSTRET:  m_minstret[31:0] = v;
      `CSR_MINSTRETH: m_minstret[63:32] = v;
      default: ;
    endcase
  endfunction

  // one clock edge of the machine state, with the issue seen at that edge.
  function automatic void model_step(input csr_issue_t iss, output csr_result_t res,
                                     output csr_redirect_t red);
    logic [2:0] f3;
    logic [4:0] rs1f;
    logic [4:0] rdf;
    csr_addr_t  a;
    logic       is_csr;
    logic       is_mret;
    logic       known;
    logic       writes;
    logic       illegal;
    logic       irq;
    cause_t     cause;
    xlen_t      old;
    xlen_t      src;
    xlen_t      nv;
    f3      = iss.instr[14:12];
    rs1f    = iss.instr[19:15];
    rdf     = iss.instr[11:7];
    a       = iss.instr[31:20];
    is_mret = iss.instr == `MRET_INSTR;
    is_csr  = (iss.instr[6:0] == `OPCODE_SYSTEM) && (f3 != 3'b000) && (f3 != 3'b100);
    known   = a inside {`CSR_MSTATUS, `CSR_MISA, `CSR_MIE, `CSR_MTVEC, `CSR_MSCRATCH,
                        `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_MIP, `CSR_MCYCLE,
                        `CSR_MINSTRET, `CSR_MCYCLEH, `CSR_MINSTRETH, `CSR_MVENDORID,
                        `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID};
    writes  = is_csr && (f3[1:0] == 2'b01 || rs1f != 5'd0);
    illegal = !is_mret &&
              (!is_csr || !known || (writes && (a[11:10] == 2'b11 || a == `CSR_MISA)));
    src     = f3[2] ? {27'd0, rs1f} : iss.rs1_data;
    old     = model_read(a);
    case (f3[1:0])
      2'b01:   nv = src;
      2'b10:   nv = old | src;
      default: nv = old & ~src;
    endcase
    irq = m_mstatus.mie && ((m_mie.meie && m_mip.meip) || (m_mie.mtie && m_mip.mtip) ||
                            (m_mie.msie && m_mip.msip));
    if (m_mie.meie && m_mip.meip) begin
      cause = `IRQ_M_EXT;
    end else if (m_mie.mtie && m_mip.mtip) begin
      cause = `IRQ_M_TIMER;
    end else begin
      cause = `IRQ_M_SOFT;
    end
    res = '0;
    red = '0;
    m_mcycle = m_mcycle + 64'd1;
    if (iss.valid && (illegal || irq)) begin
      red.valid      = 1'b1;
      red.pc         = {m_mtvec[31:2], 2'b00};
      m_mstatus.mpie = m_mstatus.mie;
      m_mstatus.mie  = 1'b0;
      m_mstatus.mpp  = `PRIV_M;
      m_mepc         = iss.pc;
      if (illegal) begin
        m_mcause = {28'd0, `CAUSE_ILLEGAL};
        m_mtval  = iss.instr;
      end else begin
        m_mcause = {1'b1, 27'd0, cause};
        m_mtval  = '0;
        if (m_mtvec[0]) begin
          red.pc = red.pc + {26'd0, cause, 2'b00};   // vectored entry.
        end
      end
    end else if (iss.valid && is_mret) begin
      red.valid      = 1'b1;
      red.pc         = m_mepc;
      m_mstatus.mie  = m_mstatus.mpie;
      m_mstatus.mpie = 1'b1;
      m_mstatus.mpp  = `PRIV_U;
      m_minstret     = m_minstret + 64'd1;
    end else if (iss.valid) begin
      res.valid   = 1'b1;
      res.rd      = rdf;
      res.rd_data = (f3[1:0] == 2'b01 && rdf == 5'd0) ? '0 : old;
      m_minstret  = m_minstret + 64'd1;
      if (writes) begin
        model_write(a, nv);   // counter writes override the increment.
      end
    end
    m_mip.meip = meip;
    m_mip.mtip = mtip;
    m_mip.msip = msip;
  endfunction

  task automatic stop_with_failure();
    $display("Errors found");
    $fatal(1, "run stopped at the first failing check");
  endtask

  task automatic check_result(input string name, input csr_result_t exp,
                              input csr_result_t act);
    if (act.valid !== exp.valid) begin
      if (exp.valid) begin
        $display("%s: the expected rd writeback did not appear", name);
      end else begin
        $display("%s: an rd writeback appeared with no instruction to retire", name);
      end
      stop_with_failure();
    end else if (exp.valid && act !== exp) begin
      $display("CHECK FAILED %s result expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_redirect(input string name, input csr_redirect_t exp,
                                input csr_redirect_t act);
    if (act.valid !== exp.valid) begin
      if (exp.valid) begin
        $display("%s: the expected pc redirect did not appear", name);
      end else begin
        $display("%s: a pc redirect appeared with no trap or mret", name);
      end
      stop_with_failure();
    end else if (exp.valid && act !== exp) begin
      $display("CHECK FAILED %s redirect expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  // outputs are stable at the falling edge.
  always @(negedge clock) begin
    if (checking) begin
      check_result(test_name, exp_result, result);
      check_redirect(test_name, exp_redirect, redirect);
    end
  end

  task automatic run_cycle(input csr_issue_t iss);
    csr_result_t   res;
    csr_redirect_t red;
    issue = iss;
    model_step(iss, res, red);
    @(posedge clock);
    #1;
    exp_result   = res;
    exp_redirect = red;
  endtask

  task automatic issue_instr(input xlen_t instr, input xlen_t rs1_data);
    csr_issue_t iss;
    iss.valid    = 1'b1;
    iss.instr    = instr;
    iss.rs1_data = rs1_data;
    iss.pc       = next_pc;
    next_pc      = next_pc + 32'd4;
    run_cycle(iss);
  endtask

  task automatic idle(input int n);
    csr_issue_t iss;
    iss = '0;
    repeat (n) run_cycle(iss);
  endtask

  task automatic read_csr(input csr_addr_t a);
    issue_instr(encode_csr(`FUNCT3_CSRRS, a, 5'd0, 5'd10), '0);
  endtask

  task automatic test_random_rmw();
    xlen_t      r;
    xlen_t      data;
    logic [2:0] f3;
    csr_addr_t  a;
    logic [4:0] rs1f;
    test_name = "random read-modify-write";
    for (int i = 0; i < n_random; i++) begin
      r    = $random(seed);
      data = $random(seed);
      case (r[2:0])
        3'd0:    f3 = `FUNCT3_CSRRW;
        3'd1:    f3 = `FUNCT3_CSRRS;
        3'd2:    f3 = `FUNCT3_CSRRC;
        3'd3:    f3 = `FUNCT3_CSRRWI;
        3'd4:    f3 = `FUNCT3_CSRRSI;
        default: f3 = `FUNCT3_CSRRCI;
      endcase
      case (r[5:4])
        2'b00:   a = `CSR_MSCRATCH;
        2'b01:   a = `CSR_MTVEC;
        default: a = `CSR_MEPC;
      endcase
      rs1f = (r[9:8] == 2'b00) ? 5'd0 : r[14:10];
      if (!f3[2] && rs1f == 5'd0) begin
        data = '0;   // x0.
      end
      issue_instr(encode_csr(f3, a, rs1f, r[19:15]), data);
      read_csr(a);
    end
  endtask

  task automatic test_read_only();
    test_name = "read-only and illegal";
    issue_instr(encode_csr(`FUNCT3_CSRRW, `CSR_MTVEC, 5'd1, 5'd0), 32'h0000_0100);
    read_csr(`CSR_MISA);
    read_csr(`CSR_MVENDORID);
    read_csr(`CSR_MARCHID);
    read_csr(`CSR_MIMPID);
    read_csr(`CSR_MHARTID);
    issue_instr(encode_csr(`FUNCT3_CSRRW, `CSR_MISA, 5'd6, 5'd1), 32'h0);
    read_csr(`CSR_MCAUSE);
    read_csr(`CSR_MTVAL);
    issue_instr(32'h0000_0073, '0);   // ecall has no handler here.
    read_csr(`CSR_MCAUSE);
    read_csr(`CSR_MTVAL);
    issue_instr(encode_csr(`FUNCT3_CSRRS, 12'h7c0, 5'd0, 5'd2), '0);
    issue_instr(encode_csr(`FUNCT3_CSRRSI, `CSR_MHARTID, 5'd1, 5'd2), '0);
    read_csr(`CSR_MTVAL);
    idle(2);
  endtask

  task automatic test_interrupts();
    test_name = "timer interrupt";
    issue_instr(encode_csr(`FUNCT3_CSRRW, `CSR_MTVEC, 5'd2, 5'd0), 32'h0000_0201);
    issue_instr(encode_csr(`FUNCT3_CSRRS, `CSR_MIE, 5'd2, 5'd0), 32'h0000_0080);
    issue_instr(encode_csr(`FUNCT3_CSRRSI, `CSR_MSTATUS, 5'd8, 5'd0), '0);
    mtip = 1'b1;
    idle(1);
    read_csr(`CSR_MSCRATCH);   // taken as the interrupt.
    mtip = 1'b0;
    idle(2);
    read_csr(`CSR_MEPC);
    read_csr(`CSR_MCAUSE);
    test_name = "external over timer";
    meip = 1'b1;
    mtip = 1'b1;
    issue_instr(encode_csr(`FUNCT3_CSRRS, `CSR_MIE, 5'd3, 5'd0), 32'h0000_0800);
    issue_instr(encode_csr(`FUNCT3_CSRRSI, `CSR_MSTATUS, 5'd8, 5'd0), '0);
    read_csr(`CSR_MSCRATCH);
    test_name = "pending with mie clear";
    read_csr(`CSR_MCAUSE);
    read_csr(`CSR_MEPC);
    read_csr(`CSR_MIP);
    meip = 1'b0;
    mtip = 1'b0;
    idle(2);
    test_name = "mret";
    issue_instr(`MRET_INSTR, '0);
    read_csr(`CSR_MSTATUS);
    test_name = "software interrupt";
    issue_instr(encode_csr(`FUNCT3_CSRRSI, `CSR_MIE, 5'd8, 5'd0), '0);
    msip = 1'b1;
    idle(1);
    read_csr(`CSR_MSCRATCH);
    msip = 1'b0;
    idle(2);
    read_csr(`CSR_MCAUSE);
    read_csr(`CSR_MSTATUS);
  endtask

  task automatic test_counters();
    test_name = "counters";
    read_csr(`CSR_MINSTRET);
    issue_instr(encode_csr(`FUNCT3_CSRRW, `CSR_MSCRATCH, 5'd3, 5'd0), 32'h5);
    idle(2);
    issue_instr(32'h0010_0073, '0);   // ebreak traps and does not retire.
    read_csr(`CSR_MINSTRET);
    read_csr(`CSR_MCYCLE);
    idle(3);
    read_csr(`CSR_MCYCLE);
    read_csr(`CSR_MCYCLEH);
    read_csr(`CSR_MINSTRETH);
    issue_instr(encode_csr(`FUNCT3_CSRRW, `CSR_MCYCLE, 5'd4, 5'd0), 32'h0000_0100);
    read_csr(`CSR_MCYCLE);
    issue_instr(encode_csr(`FUNCT3_CSRRW, `CSR_MINSTRET, 5'd4, 5'd0), 32'h0000_0020);
    read_csr(`CSR_MINSTRET);
    idle(2);
  endtask

  initial begin
    #(test_cycles * clock_period + 100);
    $display("watchdog expired before the tests finished");
    $display("Errors found");
    $fatal(1, "timeout");
  end

  initial begin
    seed         = 32'hefdc7121;
    reset        = 1'b0;
    issue        = '0;
    meip         = 1'b0;
    mtip         = 1'b0;
    msip         = 1'b0;
    exp_result   = '0;
    exp_redirect = '0;
    checking     = 1'b0;
    test_name    = "reset";
    next_pc      = 32'h0000_1000;
    m_mstatus    = '0;
    m_mie        = '0;
    m_mip        = '0;
    m_mtvec      = '0;
    m_mscratch   = '0;
    m_mepc       = '0;
    m_mcause     = '0;
    m_mtval      = '0;
    m_mcycle     = '0;
    m_minstret   = '0;
    repeat (4) @(posedge clock);
    #1;
    reset    = 1'b1;
    checking = 1'b1;
    idle(2);
    test_random_rmw();
    test_read_only();
    test_interrupts();
    test_counters();
    @(negedge clock);
    #1;   // last compare at this falling edge is done.
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# builds the csr unit testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module csr_unit_tb -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vcsr_unit_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "No errors"; then
  exit 0
fi
exit 1
